//--- Bender.yml
package:
  name: ncpu32k

sources:
  - verilog/ncpu32k_pkg.sv
  - verilog/ncpu32k_issue_if.sv
  - verilog/ncpu32k_fetch.sv
  - verilog/ncpu32k_regfile.sv
  - verilog/ncpu32k_decode.sv
  - verilog/ncpu32k_exec.sv
  - verilog/ncpu32k_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ncpu32k_tb.sv

//--- ncpu32k.f
+incdir+test
verilog/ncpu32k_pkg.sv
verilog/ncpu32k_issue_if.sv
verilog/ncpu32k_fetch.sv
verilog/ncpu32k_regfile.sv
verilog/ncpu32k_decode.sv
verilog/ncpu32k_exec.sv
verilog/ncpu32k_core.sv
test/ncpu32k_tb.sv

//--- test/ncpu32k_tb_prog.svh
//////////////////////////////////////////////////////////////////////
// ncpu32k testbench helpers
// Instruction encoders, the LFSR and small program and run tasks
//////////////////////////////////////////////////////////////////////

`ifndef NCPU32K_TB_PROG_SVH
`define NCPU32K_TB_PROG_SVH

function automatic logic [31:0] enc_r(input logic [5:0] op, input int rd, input int rs1,
                                      input int rs2);
   return {11'd0, rs2[4:0], rs1[4:0], rd[4:0], op};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input int rd, input int rs1,
                                      input logic [15:0] imm);
   return {imm, rs1[4:0], rd[4:0], op};
endfunction

// PC-relative jump, offset in bytes
function automatic logic [31:0] enc_j(input logic [31:0] offset);
   return {offset[22:2], 5'd0, OP_JMP_I};
endfunction

function automatic logic [31:0] sext16(input logic [15:0] imm);
   return {{16{imm[15]}}, imm};
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
   end
   return r;
endfunction

task automatic emit(input logic [31:0] word);
   imem[prog_pc] = word;
   prog_pc += 4;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
   exp_a[exp_n] = addr;
   exp_d[exp_n] = data;
   exp_n++;
endtask

task automatic reset_core();
   @(posedge clk_i);
   #1 rst_n_i = 1'b0;
   repeat (4) @(posedge clk_i);
   #1 rst_n_i = 1'b1;
endtask

task automatic run_until(input logic [31:0] stop);
   @(posedge clk_i);
   #2;
   while (iaddr_o != stop) begin
      @(posedge clk_i);
      #2;
   end
endtask

`endif

//--- test/ncpu32k_tb.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k testbench
// Instruction and data bus models, concurrent checks on fetch, the
// data bus and every store, and six directed programs
//////////////////////////////////////////////////////////////////////

module ncpu32k_tb;
   import ncpu32k_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int TEST_BUDGET     = 330;   // Worst case cycles per program
   localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_BUDGET + 20;

   logic          clk_i = 1'b0;
   logic          rst_n_i, insn_ready_i, dbus_rd_ready_i, dbus_we_done_i;
   logic [31:0]   d_i, insn_i;
   wire  [31:0]   d_o, addr_o, iaddr_o;
   wire           dbus_rd_o, dbus_we_o, ibus_rd_o;

   logic [31:0]   imem [logic [31:0]];
   logic [31:0]   dmem [logic [31:0]];
   logic [31:0]   exp_a [64];
   logic [31:0]   exp_d [64];
   int            exp_n, st_idx, errors, errors_at_start, tests_run, tests_bad;
   logic [31:0]   prog_pc, lfsr_state = 32'hd77334b1;
   logic [31:0]   iaddr_seen, iaddr_prev, exp_cur_a, exp_cur_d;
   logic          seq_check_en = 0, jmp_check_en = 0, rand_ready_en = 0;
   logic          rst_seen, rand_seen, bus_active, done_q, done_was_store;
   logic [1:0]    bus_wait;
   int            store_k;

   `include "ncpu32k_tb_prog.svh"

   ncpu32k_core DUT (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .d_i(d_i), .insn_i(insn_i),
      .insn_ready_i(insn_ready_i), .dbus_rd_ready_i(dbus_rd_ready_i),
      .dbus_we_done_i(dbus_we_done_i), .d_o(d_o), .addr_o(addr_o),
      .dbus_rd_o(dbus_rd_o), .dbus_we_o(dbus_we_o), .iaddr_o(iaddr_o),
      .ibus_rd_o(ibus_rd_o)
   );

   always #50 clk_i = ~clk_i;

   wire bus_stall = (dbus_rd_o && !dbus_rd_ready_i) || (dbus_we_o && !dbus_we_done_i);
   assign exp_cur_a = exp_a[st_idx[5:0]];
   assign exp_cur_d = exp_d[st_idx[5:0]];

   function void count_error();
      errors++;
   endfunction

   // Unwritten words read back a pattern of their address
   function automatic logic [31:0] read_word(input logic [31:0] addr);
      if (dmem.exists(addr))
         return dmem[addr];
      return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus models, driven 1 unit after the clock edge
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk_i) begin
      rst_seen  = rst_n_i;
      rand_seen = rand_ready_en;
      #1;
      iaddr_prev = iaddr_seen;
      iaddr_seen = iaddr_o;
      dbus_rd_ready_i = 1'b0;
      dbus_we_done_i  = 1'b0;
      if (!rst_seen) begin
         bus_active = 1'b0;
         done_q     = 1'b0;
         st_idx     = 0;
      end else begin
         if (done_q && done_was_store)
            st_idx++;              // Store retired on this edge
         done_q = 1'b0;
         if (dbus_rd_o || dbus_we_o) begin
            if (!bus_active) begin
               bus_active = 1'b1;
               bus_wait   = rand_bits(2);
            end
            if (bus_wait == 0) begin
               bus_active     = 1'b0;
               done_q         = 1'b1;
               done_was_store = dbus_we_o;
               if (dbus_we_o) begin
                  dmem[addr_o]   = d_o;
                  dbus_we_done_i = 1'b1;
               end else begin
                  d_i             = read_word(addr_o);
                  dbus_rd_ready_i = 1'b1;
               end
            end else begin
               bus_wait--;
            end
         end
      end
      insn_ready_i = rand_seen ? rand_bits(1) : 1'b1;
      insn_i       = imem.exists(iaddr_o) ? imem[iaddr_o] : 32'h0;   // Empty slots are barr
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////
   a_reset_pc: assert property (@(posedge clk_i) $rose(rst_n_i) |-> iaddr_o == ERST_VECTOR)
      else begin
         count_error();
         $display("FAIL iaddr_o: got %h expected %h", $sampled(iaddr_o), ERST_VECTOR);
      end

   a_reset_strobes: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !dbus_rd_o && !dbus_we_o)
      else begin
         count_error();
         $display("A data bus strobe was high right after reset");
      end

   a_ibus_read: assert property (@(posedge clk_i) disable iff (!rst_n_i) ibus_rd_o)
      else begin
         count_error();
         $display("FAIL ibus_rd_o: got %h expected %h", $sampled(ibus_rd_o), 1'b1);
      end

   a_seq_step: assert property (@(posedge clk_i) disable iff (!rst_n_i || !seq_check_en)
      insn_ready_i && !bus_stall |=> iaddr_o == $past(iaddr_o) + 32'd4)
      else begin
         count_error();
         $display("FAIL iaddr_o: got %h expected %h", $sampled(iaddr_o), iaddr_prev + 32'd4);
      end

   a_seq_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || !seq_check_en)
      !(insn_ready_i && !bus_stall) |=> $stable(iaddr_o))
      else begin
         count_error();
         $display("FAIL iaddr_o: got %h expected %h", $sampled(iaddr_o), iaddr_prev);
      end

   a_bus_steady: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bus_stall |=> $stable(iaddr_o) && $stable(addr_o) && $stable(d_o))
      else begin
         count_error();
         $display("iaddr_o, addr_o or d_o moved while a memory access waited");
      end

   a_jump_target: assert property (@(posedge clk_i) disable iff (!rst_n_i || !jmp_check_en)
      iaddr_o == 32'h108 && insn_ready_i && !bus_stall |=> iaddr_o == 32'h148)
      else begin
         count_error();
         $display("FAIL iaddr_o: got %h expected %h", $sampled(iaddr_o), 32'h148);
      end

   a_store_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbus_we_o && dbus_we_done_i |-> st_idx < exp_n)
      else begin
         count_error();
         $display("A store completed that the program does not contain");
      end

   a_store_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbus_we_o && dbus_we_done_i && st_idx < exp_n |-> addr_o == exp_cur_a)
      else begin
         count_error();
         $display("FAIL addr_o: got %h expected %h", $sampled(addr_o), $sampled(exp_cur_a));
      end

   a_store_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbus_we_o && dbus_we_done_i && st_idx < exp_n |-> d_o == exp_cur_d)
      else begin
         count_error();
         $display("FAIL d_o: got %h expected %h", $sampled(d_o), $sampled(exp_cur_d));
      end

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////
   task automatic begin_test();
      imem.delete();
      exp_n           = 0;
      store_k         = 0;
      prog_pc         = ERST_VECTOR;
      errors_at_start = errors;
   endtask

   task automatic end_test(input string name);
      @(posedge clk_i);
      #2;
      assert (st_idx == exp_n) else begin
         count_error();
         $display("%s finished with %0d stores, %0d expected", name, st_idx, exp_n);
      end
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", name, errors - errors_at_start);
      end
   endtask

   // Result in r3, stored right away through base r5
   task automatic store_result(input logic [31:0] word, input logic [31:0] res);
      logic [15:0] off;
      off = store_k[0] ? 16'hff00 + 16'(store_k * 4) : 16'h0010 + 16'(store_k * 4);
      emit(word);
      emit(enc_i(OP_STW, 3, 5, off));
      expect_store(32'h1000 + sext16(off), res);
      store_k++;
   endtask

   task automatic logic_adder_test();
      logic [31:0] a, b;
      logic [15:0] imm;
      a = rand_bits(32);
      b = rand_bits(32);
      dmem[32'h200] = a;
      dmem[32'h204] = b;
      emit(enc_i(OP_LDWU, 1, 0, 16'h0200));
      emit(enc_i(OP_LDWU, 2, 0, 16'h0204));
      emit(enc_i(OP_OR_I, 5, 0, 16'h1000));
      store_result(enc_r(OP_AND, 3, 1, 2), a & b);
      store_result(enc_r(OP_OR, 3, 1, 2), a | b);
      store_result(enc_r(OP_XOR, 3, 1, 2), a ^ b);
      store_result(enc_r(OP_LSL, 3, 1, 2), a << b[4:0]);
      store_result(enc_r(OP_LSR, 3, 1, 2), a >> b[4:0]);
      store_result(enc_r(OP_ASR, 3, 1, 2), $signed(a) >>> b[4:0]);
      store_result(enc_r(OP_ADD, 3, 1, 2), a + b);
      store_result(enc_r(OP_SUB, 3, 1, 2), a - b);
      imm = rand_bits(16);
      store_result(enc_i(OP_AND_I, 3, 1, imm), a & sext16(imm));
      imm = rand_bits(16);
      store_result(enc_i(OP_OR_I, 3, 1, imm), a | {16'h0, imm});
      imm = rand_bits(16);
      store_result(enc_i(OP_XOR_I, 3, 1, imm), a ^ sext16(imm));
      imm = rand_bits(16);
      store_result(enc_i(OP_LSL_I, 3, 1, imm), a << imm[4:0]);
      imm = rand_bits(16);
      store_result(enc_i(OP_LSR_I, 3, 1, imm), a >> imm[4:0]);
      imm = rand_bits(16);
      store_result(enc_i(OP_ASR_I, 3, 1, imm), $signed(a) >>> imm[4:0]);
      imm = rand_bits(16);
      store_result(enc_i(OP_ADD_I, 3, 1, imm), a + sext16(imm));
   endtask

   task automatic load_store_test();
      logic [31:0] la;
      for (int i = 0; i < 4; i++) begin
         la = 32'h600 + 32'(i * 8);
         if (i[0] == 1'b0)
            dmem[la] = rand_bits(32);   // Odd slots keep the address pattern
         emit(enc_i(OP_LDWU, 6, 0, la[15:0]));
         emit(enc_i(OP_STW, 6, 0, 16'h0700 + 16'(i * 4)));
         expect_store(32'h700 + 32'(i * 4), read_word(la));
      end
      // Read back a word this program stored
      emit(enc_i(OP_LDWU, 10, 0, 16'h0700));
      emit(enc_i(OP_STW, 10, 0, 16'h0780));
      expect_store(32'h780, read_word(32'h600));
   endtask

   initial begin
      rst_n_i         = 1'b0;
      insn_i          = '0;
      insn_ready_i    = 1'b1;
      d_i             = '0;
      dbus_rd_ready_i = 1'b0;
      dbus_we_done_i  = 1'b0;
      errors          = 0;
      tests_run       = 0;
      tests_bad       = 0;

      begin_test();
      reset_core();
      run_until(ERST_VECTOR + 32'd16);
      end_test("reset");

      // Stores among the padding make the pipeline stall
      begin_test();
      for (int i = 0; i < 30; i++) begin
         if (i % 5 == 4) begin
            emit(enc_i(OP_STW, 0, 0, 16'h0400 + 16'(i * 4)));
            expect_store(32'h400 + 32'(i * 4), 32'h0);
         end else begin
            emit(enc_i(OP_OR_I, 11, 11, 16'(i)));
         end
      end
      seq_check_en  = 1'b1;
      rand_ready_en = 1'b1;
      reset_core();
      run_until(prog_pc + 32'd16);
      rand_ready_en = 1'b0;
      seq_check_en  = 1'b0;
      end_test("sequential_fetch");

      begin_test();
      logic_adder_test();
      reset_core();
      run_until(prog_pc + 32'd16);
      end_test("logic_adder");

      begin_test();
      load_store_test();
      reset_core();
      run_until(prog_pc + 32'd16);
      end_test("load_store");

      begin_test();
      emit(enc_i(OP_OR_I, 7, 0, 16'h0011));
      emit(enc_j(32'h40));
      emit(enc_i(OP_OR_I, 8, 0, 16'h0022));   // Delay slot
      emit(enc_i(OP_OR_I, 7, 0, 16'h0099));   // Skipped
      prog_pc = 32'h148;
      emit(enc_i(OP_STW, 7, 0, 16'h0300));
      emit(enc_i(OP_STW, 8, 0, 16'h0304));
      expect_store(32'h300, 32'h11);
      expect_store(32'h304, 32'h22);
      jmp_check_en = 1'b1;
      reset_core();
      run_until(prog_pc + 32'd16);
      jmp_check_en = 1'b0;
      end_test("jump");

      begin_test();
      emit(enc_i(OP_OR_I, 0, 0, 16'h0055));
      emit(enc_i(OP_STW, 0, 0, 16'h0500));
      emit(enc_i(OP_ADD_I, 0, 0, 16'h1234));
      emit(enc_i(OP_OR_I, 12, 0, 16'h0077));
      emit(enc_i(OP_STW, 0, 0, 16'h0504));
      expect_store(32'h500, 32'h0);
      expect_store(32'h504, 32'h0);
      reset_core();
      run_until(prog_pc + 32'd16);
      end_test("register_zero");

      $display("%0d tests, %0d with errors, %0d errors in total", tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- verilog/ncpu32k_core.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k core
// Three-stage in-order 32-bit integer core. Fetch, decode with the
// register file, and execute with memory access and writeback
//////////////////////////////////////////////////////////////////////

module ncpu32k_core #(
   parameter logic [ncpu32k_pkg::AW-1:0] RST_VECTOR = ncpu32k_pkg::ERST_VECTOR,
   parameter int                         NUM_REGS   = 32
) (
   input                          clk_i,
   input                          rst_n_i,
   input  [ncpu32k_pkg::DW-1:0]   d_i,              // Load data
   input  [ncpu32k_pkg::IW-1:0]   insn_i,
   input                          insn_ready_i,
   input                          dbus_rd_ready_i,  // Load data valid
   input                          dbus_we_done_i,   // Store complete
   output [ncpu32k_pkg::DW-1:0]   d_o,              // Store data
   output [ncpu32k_pkg::AW-1:0]   addr_o,
   output                         dbus_rd_o,
   output                         dbus_we_o,
   output [ncpu32k_pkg::AW-1:0]   iaddr_o,
   output                         ibus_rd_o
);
   import ncpu32k_pkg::*;

   wire [IW-1:0]     dec_insn;
   wire              exec_ready;
   wire              jmp;
   wire [AW-1:0]     jmp_offset;
   wire [REG_AW-1:0] rs1_addr;
   wire [REG_AW-1:0] rs2_addr;
   wire              rs1_re;
   wire              rs2_re;
   wire [DW-1:0]     rs1_data;
   wire [DW-1:0]     rs2_data;
   wire              rd_we;
   wire [REG_AW-1:0] rd_addr;
   wire [DW-1:0]     rd_data;

   ncpu32k_issue_if issue_bus ();

   assign ibus_rd_o = 1'b1;   // Instruction bus always reading

   ncpu32k_fetch #(.RST_VECTOR(RST_VECTOR)) fetch0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .insn_i(insn_i), .insn_ready_i(insn_ready_i), .exec_ready_i(exec_ready),
      .jmp_i(jmp), .jmp_offset_i(jmp_offset),
      .iaddr_o(iaddr_o), .insn_o(dec_insn)
   );

   ncpu32k_regfile #(.NUM_REGS(NUM_REGS)) regfile0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .rs1_re_i(rs1_re), .rs2_re_i(rs2_re),
      .rd_we_i(rd_we), .rd_addr_i(rd_addr), .rd_i(rd_data),
      .rs1_o(rs1_data), .rs2_o(rs2_data)
   );

   ncpu32k_decode decode0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .insn_i(dec_insn), .exec_ready_i(exec_ready),
      .rs1_i(rs1_data), .rs2_i(rs2_data),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
      .rs1_re_o(rs1_re), .rs2_re_o(rs2_re),
      .jmp_o(jmp), .jmp_offset_o(jmp_offset),
      .issue(issue_bus.dec)
   );

   ncpu32k_exec exec0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .issue(issue_bus.exe),
      .d_i(d_i), .dbus_rd_ready_i(dbus_rd_ready_i), .dbus_we_done_i(dbus_we_done_i),
      .exec_ready_o(exec_ready),
      .rd_we_o(rd_we), .rd_addr_o(rd_addr), .rd_o(rd_data),
      .addr_o(addr_o), .d_o(d_o),
      .dbus_rd_o(dbus_rd_o), .dbus_we_o(dbus_we_o)
   );

endmodule

//--- verilog/ncpu32k_decode.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k decode stage
// Splits the instruction into fields, decodes the opcode, reads the
// register file, selects operands and loads the issue registers
//////////////////////////////////////////////////////////////////////

module ncpu32k_decode (
   input                                     clk_i,
   input                                     rst_n_i,
   input  [ncpu32k_pkg::IW-1:0]              insn_i,
   input                                     exec_ready_i,
   input  [ncpu32k_pkg::DW-1:0]              rs1_i,
   input  [ncpu32k_pkg::DW-1:0]              rs2_i,
   output logic [ncpu32k_pkg::REG_AW-1:0]    rs1_addr_o,
   output logic [ncpu32k_pkg::REG_AW-1:0]    rs2_addr_o,
   output logic                              rs1_re_o,
   output logic                              rs2_re_o,
   output logic                              jmp_o,
   output logic [ncpu32k_pkg::AW-1:0]        jmp_offset_o,
   ncpu32k_issue_if.dec                      issue
);
   import ncpu32k_pkg::*;

   ////////////////////////////////////////////////////////////////////
   // Fields and opcode decode
   ////////////////////////////////////////////////////////////////////
   wire [5:0]        f_opcode = insn_i[5:0];
   wire [REG_AW-1:0] f_rd     = insn_i[10:6];
   wire [REG_AW-1:0] f_rs1    = insn_i[15:11];
   wire [REG_AW-1:0] f_rs2    = insn_i[20:16];
   wire [15:0]       f_imm16  = insn_i[31:16];
   wire [20:0]       f_rel21  = insn_i[31:11];

   wire op_and   = (f_opcode == OP_AND);
   wire op_and_i = (f_opcode == OP_AND_I);
   wire op_or    = (f_opcode == OP_OR);
   wire op_or_i  = (f_opcode == OP_OR_I);
   wire op_xor   = (f_opcode == OP_XOR);
   wire op_xor_i = (f_opcode == OP_XOR_I);
   wire op_lsl   = (f_opcode == OP_LSL);
   wire op_lsl_i = (f_opcode == OP_LSL_I);
   wire op_lsr   = (f_opcode == OP_LSR);
   wire op_lsr_i = (f_opcode == OP_LSR_I);
   wire op_asr   = (f_opcode == OP_ASR);
   wire op_asr_i = (f_opcode == OP_ASR_I);
   wire op_add   = (f_opcode == OP_ADD);
   wire op_add_i = (f_opcode == OP_ADD_I);
   wire op_sub   = (f_opcode == OP_SUB);
   wire op_ldwu  = (f_opcode == OP_LDWU);
   wire op_stw   = (f_opcode == OP_STW);
   wire op_jmp_i = (f_opcode == OP_JMP_I);   // barr and unknown codes fall through

   lu_op_t lu_op;
   au_op_t au_op;

   assign lu_op.lu_and = op_and | op_and_i;
   assign lu_op.lu_or  = op_or | op_or_i;
   assign lu_op.lu_xor = op_xor | op_xor_i;
   assign lu_op.lu_lsl = op_lsl | op_lsl_i;
   assign lu_op.lu_lsr = op_lsr | op_lsr_i;
   assign lu_op.lu_asr = op_asr | op_asr_i;
   assign au_op.au_add = op_add | op_add_i;
   assign au_op.au_sub = op_sub;

   wire alu_sel    = (|lu_op) | (|au_op);
   wire insn_imm   = op_and_i | op_or_i | op_xor_i | op_lsl_i | op_lsr_i | op_asr_i |
                     op_add_i | op_ldwu | op_stw;
   wire imm_signed = op_xor_i | op_and_i | op_add_i | op_ldwu | op_stw;
   wire wb_en      = alu_sel | op_ldwu;

   wire [DW-1:0] imm_oper = {{(DW-16){imm_signed & f_imm16[15]}}, f_imm16};

   // Store data comes from the rd field on port 2
   assign rs1_addr_o = f_rs1;
   assign rs1_re_o   = alu_sel | op_ldwu | op_stw;
   assign rs2_addr_o = op_stw ? f_rd : f_rs2;
   assign rs2_re_o   = (alu_sel & !insn_imm) | op_stw;

   assign jmp_o        = op_jmp_i;
   assign jmp_offset_o = {{(AW-23){f_rel21[20]}}, f_rel21, 2'b00};

   ////////////////////////////////////////////////////////////////////
   // Issue registers
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         issue.lu_op    <= '0;
         issue.au_op    <= '0;
         issue.mu_load  <= 1'b0;
         issue.mu_store <= 1'b0;
         issue.wb_en    <= 1'b0;
      end else if (exec_ready_i) begin
         issue.lu_op    <= lu_op;
         issue.au_op    <= au_op;
         issue.mu_load  <= op_ldwu;
         issue.mu_store <= op_stw;
         issue.wb_en    <= wb_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (exec_ready_i) begin
         issue.operand_1  <= rs1_i;
         issue.operand_2  <= insn_imm ? imm_oper : rs2_i;
         issue.store_data <= op_stw ? rs2_i : '0;
         issue.wb_addr    <= f_rd;
      end
   end

   // Execute relies on a single unit driving the result
   a_unit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({issue.lu_op, issue.au_op}));

endmodule

//--- verilog/ncpu32k_exec.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k execute stage
// Logic unit, adder and memory strobes. Selects the writeback value
// and stalls the pipeline while the data bus is busy
//////////////////////////////////////////////////////////////////////

module ncpu32k_exec (
   input                                  clk_i,
   input                                  rst_n_i,
   ncpu32k_issue_if.exe                   issue,
   input  [ncpu32k_pkg::DW-1:0]           d_i,
   input                                  dbus_rd_ready_i,
   input                                  dbus_we_done_i,
   output logic                           exec_ready_o,
   output logic                           rd_we_o,
   output logic [ncpu32k_pkg::REG_AW-1:0] rd_addr_o,
   output logic [ncpu32k_pkg::DW-1:0]     rd_o,
   output logic [ncpu32k_pkg::AW-1:0]     addr_o,
   output logic [ncpu32k_pkg::DW-1:0]     d_o,
   output logic                           dbus_rd_o,
   output logic                           dbus_we_o
);
   import ncpu32k_pkg::*;

   function automatic logic [DW-1:0] reverse_bits(input logic [DW-1:0] a);
      logic [DW-1:0] r;
      for (int i = 0; i < DW; i++) begin
         r[DW-1-i] = a[i];
      end
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Logic unit
   ////////////////////////////////////////////////////////////////////
   wire [DW-1:0] lu_and = issue.operand_1 & issue.operand_2;
   wire [DW-1:0] lu_or  = issue.operand_1 | issue.operand_2;
   wire [DW-1:0] lu_xor = issue.operand_1 ^ issue.operand_2;

   // Left shifts run through the right shifter on reversed bits
   wire [DW-1:0]   shift_lsw = issue.lu_op.lu_lsl ? reverse_bits(issue.operand_1)
                                                  : issue.operand_1;
   wire [DW-1:0]   shift_msw = issue.lu_op.lu_asr ? {DW{issue.operand_1[DW-1]}} : '0;
   wire [2*DW-1:0] shift_wide = {shift_msw, shift_lsw} >> issue.operand_2[4:0];
   wire [DW-1:0]   lu_shift = issue.lu_op.lu_lsl ? reverse_bits(shift_wide[DW-1:0])
                                                 : shift_wide[DW-1:0];
   wire            lu_op_shift = issue.lu_op.lu_lsl | issue.lu_op.lu_lsr | issue.lu_op.lu_asr;

   ////////////////////////////////////////////////////////////////////
   // Adder
   ////////////////////////////////////////////////////////////////////
   wire          adder_sub = issue.au_op.au_sub;
   wire [DW-1:0] adder_op2 = adder_sub ? ~issue.operand_2 : issue.operand_2;
   wire [DW-1:0] au_adder  = issue.operand_1 + adder_op2 + {{(DW-1){1'b0}}, adder_sub};
   wire          au_op_adder = issue.au_op.au_add | adder_sub;

   ////////////////////////////////////////////////////////////////////
   // Memory unit and writeback
   ////////////////////////////////////////////////////////////////////
   assign addr_o    = issue.operand_1 + issue.operand_2;   // Base plus offset
   assign d_o       = issue.store_data;
   assign dbus_rd_o = issue.mu_load;
   assign dbus_we_o = issue.mu_store;

   // Stall until the bus answers
   assign exec_ready_o = !(issue.mu_load & !dbus_rd_ready_i) &
                         !(issue.mu_store & !dbus_we_done_i);

   assign rd_o = ({DW{issue.lu_op.lu_and}} & lu_and) |
                 ({DW{issue.lu_op.lu_or}}  & lu_or) |
                 ({DW{issue.lu_op.lu_xor}} & lu_xor) |
                 ({DW{lu_op_shift}}        & lu_shift) |
                 ({DW{au_op_adder}}        & au_adder) |
                 ({DW{issue.mu_load}}      & d_i);

   assign rd_we_o   = issue.wb_en & exec_ready_o;
   assign rd_addr_o = issue.wb_addr;

   a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(dbus_rd_o && dbus_we_o));

endmodule

//--- verilog/ncpu32k_fetch.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k fetch stage
// Program counter with sequential and PC-relative update, and the
// fetched-instruction register that feeds decode
//////////////////////////////////////////////////////////////////////

module ncpu32k_fetch #(
   parameter logic [ncpu32k_pkg::AW-1:0] RST_VECTOR = ncpu32k_pkg::ERST_VECTOR
) (
   input                              clk_i,
   input                              rst_n_i,
   input  [ncpu32k_pkg::IW-1:0]       insn_i,
   input                              insn_ready_i,
   input                              exec_ready_i,
   input                              jmp_i,          // jmp_i sitting in decode
   input  [ncpu32k_pkg::AW-1:0]       jmp_offset_i,
   output logic [ncpu32k_pkg::AW-1:0] iaddr_o,
   output logic [ncpu32k_pkg::IW-1:0] insn_o
);
   import ncpu32k_pkg::*;

   logic          fetch_acc;
   logic [AW-1:0] pc_nxt;
   logic [IW-1:0] insn_nxt;

   assign fetch_acc = exec_ready_i & insn_ready_i;

   // Jump target is relative to the delay slot address
   assign pc_nxt = iaddr_o + (jmp_i ? jmp_offset_i : INSN_BYTES);

   // Empty cycle becomes a barrier
   // A jump stays in decode until its delay slot has been fetched
   always_comb begin
      if (insn_ready_i)
         insn_nxt = insn_i;
      else if (jmp_i)
         insn_nxt = insn_o;
      else
         insn_nxt = {{(IW-6){1'b0}}, OP_BARR};
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         iaddr_o <= RST_VECTOR;
         insn_o  <= {{(IW-6){1'b0}}, OP_BARR};
      end else begin
         if (fetch_acc)
            iaddr_o <= pc_nxt;
         if (exec_ready_i)
            insn_o <= insn_nxt;   // Held while execute stalls
      end
   end

   // Reset vector and jump offsets keep the PC on a word boundary
   a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iaddr_o[1:0] == 2'b00);

endmodule

//--- verilog/ncpu32k_issue_if.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k issue slot
// One decoded instruction on its way from decode into execute
//////////////////////////////////////////////////////////////////////

interface ncpu32k_issue_if;
   import ncpu32k_pkg::*;

   logic [DW-1:0]     operand_1;
   logic [DW-1:0]     operand_2;    // Register or extended immediate
   logic [DW-1:0]     store_data;
   lu_op_t            lu_op;
   au_op_t            au_op;
   logic              mu_load;
   logic              mu_store;
   logic              wb_en;
   logic [REG_AW-1:0] wb_addr;

   modport dec (
      output operand_1, operand_2, store_data,
      output lu_op, au_op, mu_load, mu_store,
      output wb_en, wb_addr
   );

   modport exe (
      input operand_1, operand_2, store_data,
      input lu_op, au_op, mu_load, mu_store,
      input wb_en, wb_addr
   );

endinterface

//--- verilog/ncpu32k_pkg.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k shared definitions
// Widths, opcode encodings, execution unit operation types and
// the reset vector of the three-stage integer core
//////////////////////////////////////////////////////////////////////

package ncpu32k_pkg;

   localparam int DW     = 32;    // Data width
   localparam int AW     = 32;    // Address width
   localparam int IW     = 32;    // Instruction width
   localparam int REG_AW = 5;     // Register address width

   localparam logic [AW-1:0] ERST_VECTOR = 32'h0000_0100;
   localparam logic [AW-1:0] INSN_BYTES  = AW'(4);   // PC step

   // Opcode field, bits 5..0 of every instruction
   typedef enum logic [5:0] {
      OP_BARR  = 6'h00,    // Barrier, executes as a no-op
      OP_AND   = 6'h01,
      OP_AND_I = 6'h02,
      OP_OR    = 6'h03,
      OP_OR_I  = 6'h04,
      OP_XOR   = 6'h05,
      OP_XOR_I = 6'h06,
      OP_LSL   = 6'h07,
      OP_LSL_I = 6'h08,
      OP_LSR   = 6'h09,
      OP_LSR_I = 6'h0a,
      OP_ASR   = 6'h0b,
      OP_ASR_I = 6'h0c,
      OP_ADD   = 6'h0d,
      OP_ADD_I = 6'h0e,
      OP_SUB   = 6'h0f,
      OP_LDWU  = 6'h10,
      OP_STW   = 6'h11,
      OP_JMP_I = 6'h12     // PC-relative jump with one delay slot
   } opcode_e;

   // Logic unit operation, one-hot
   typedef struct packed {
      logic lu_asr;
      logic lu_lsr;
      logic lu_lsl;
      logic lu_xor;
      logic lu_or;
      logic lu_and;
   } lu_op_t;

   // Adder operation, one-hot
   typedef struct packed {
      logic au_sub;
      logic au_add;
   } au_op_t;

endpackage

//--- verilog/ncpu32k_regfile.sv
//////////////////////////////////////////////////////////////////////
// ncpu32k register file
// Two read ports and one write port. Register 0 reads zero and a
// write in the same cycle is forwarded to a matching read
//////////////////////////////////////////////////////////////////////

module ncpu32k_regfile #(
   parameter int NUM_REGS = 32
) (
   input                                  clk_i,
   input                                  rst_n_i,
   input  [ncpu32k_pkg::REG_AW-1:0]       rs1_addr_i,
   input  [ncpu32k_pkg::REG_AW-1:0]       rs2_addr_i,
   input                                  rs1_re_i,
   input                                  rs2_re_i,
   input                                  rd_we_i,
   input  [ncpu32k_pkg::REG_AW-1:0]       rd_addr_i,
   input  [ncpu32k_pkg::DW-1:0]           rd_i,
   output logic [ncpu32k_pkg::DW-1:0]     rs1_o,
   output logic [ncpu32k_pkg::DW-1:0]     rs2_o
);
   import ncpu32k_pkg::*;

   logic [DW-1:0] regs [NUM_REGS];

   // Writes to register 0 are dropped
   always_ff @(posedge clk_i) begin
      if (rst_n_i && rd_we_i && (rd_addr_i != '0))
         regs[rd_addr_i] <= rd_i;
   end

   always_comb begin
      if (!rs1_re_i || (rs1_addr_i == '0))
         rs1_o = '0;
      else if (rd_we_i && (rd_addr_i == rs1_addr_i))
         rs1_o = rd_i;              // Write-through
      else
         rs1_o = regs[rs1_addr_i];
   end

   always_comb begin
      if (!rs2_re_i || (rs2_addr_i == '0))
         rs2_o = '0;
      else if (rd_we_i && (rd_addr_i == rs2_addr_i))
         rs2_o = rd_i;              // Write-through
      else
         rs2_o = regs[rs2_addr_i];
   end

endmodule
